//--- Makefile
# Verilator build and run for the minimac testbench.

VERILATOR ?= verilator
TOP       ?= tb_minimac
FILELIST  ?= filelist.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FILELIST)

run: compile
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TEST PASSED" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)

//--- filelist.f
+incdir+.
minimac_pkg.sv
minimac_ctlif.sv
minimac_sync.sv
minimac_memory.sv
minimac_tx.sv
minimac_rx.sv
minimac.sv
minimac_checker.sv
minimac_scoreboard.sv
tb_minimac.sv

//--- minimac.sv
/*
 * Minimac top level.
 * Ethernet MAC for an MII PHY with CSR control and a Wishbone
 * window onto the frame buffers.
 */
`timescale 1ns/100ps
`include "minimac_macros.svh"

module minimac import minimac_pkg::*; (
	input  logic        sys_clk_i,
	input  logic        reset_i,
	input  logic [13:0] csr_a_i,
	input  logic        csr_we_i,
	input  logic [31:0] csr_di_i,
	output logic [31:0] csr_do_o,
	output logic        irq_rx_o,
	output logic        irq_tx_o,
	input  logic [31:0] wb_adr_i,
	input  logic [31:0] wb_dat_i,
	output logic [31:0] wb_dat_o,
	input  logic [3:0]  wb_sel_i,
	input  logic        wb_stb_i,
	input  logic        wb_cyc_i,
	input  logic        wb_we_i,
	output logic        wb_ack_o,
	input  logic        phy_tx_clk_i,
	output logic [3:0]  phy_tx_data_o,
	output logic        phy_tx_en_o,
	output logic        phy_tx_er_o,
	input  logic        phy_rx_clk_i,
	input  logic [3:0]  phy_rx_data_i,
	input  logic        phy_dv_i,
	output logic        phy_rst_n_o
);

	sys2phy_t sys_to_phy;
	phy2sys_t phy_to_sys;

	// PHY side of the handshakes.
	logic [1:0] phy_rx_ready;
	logic [1:0] phy_rx_done;
	logic [`MINIMAC_BUF_AW-1:0] phy_rx_count_0;
	logic [`MINIMAC_BUF_AW-1:0] phy_rx_count_1;
	logic phy_tx_start;
	logic phy_tx_done;
	logic [`MINIMAC_BUF_AW-1:0] phy_tx_count;

	buf_wr_t rxb0_wr;
	buf_wr_t rxb1_wr;
	logic [`MINIMAC_BUF_AW-1:0] txb_adr;
	logic [7:0] txb_dat;

	minimac_ctlif ctlif (
		.sys_clk_i   (sys_clk_i),
		.reset_i     (reset_i),
		.csr_a_i     (csr_a_i),
		.csr_we_i    (csr_we_i),
		.csr_di_i    (csr_di_i),
		.csr_do_o    (csr_do_o),
		.irq_rx_o    (irq_rx_o),
		.irq_tx_o    (irq_tx_o),
		.phy_rst_n_o (phy_rst_n_o),
		.to_phy_o    (sys_to_phy),
		.from_phy_i  (phy_to_sys)
	);

	minimac_sync sync (
		.sys_clk_i    (sys_clk_i),
		.phy_rx_clk_i (phy_rx_clk_i),
		.phy_tx_clk_i (phy_tx_clk_i),
		.sys_to_phy_i (sys_to_phy),
		.rx_ready_o   (phy_rx_ready),
		.tx_start_o   (phy_tx_start),
		.tx_count_o   (phy_tx_count),
		.rx_done_i    (phy_rx_done),
		.rx_count_0_i (phy_rx_count_0),
		.rx_count_1_i (phy_rx_count_1),
		.tx_done_i    (phy_tx_done),
		.phy_to_sys_o (phy_to_sys)
	);

	minimac_memory memory (
		.sys_clk_i    (sys_clk_i),
		.reset_i      (reset_i),
		.phy_tx_clk_i (phy_tx_clk_i),
		.phy_rx_clk_i (phy_rx_clk_i),
		.wb_adr_i     (wb_adr_i),
		.wb_dat_i     (wb_dat_i),
		.wb_dat_o     (wb_dat_o),
		.wb_sel_i     (wb_sel_i),
		.wb_stb_i     (wb_stb_i),
		.wb_cyc_i     (wb_cyc_i),
		.wb_we_i      (wb_we_i),
		.wb_ack_o     (wb_ack_o),
		.rxb0_wr_i    (rxb0_wr),
		.rxb1_wr_i    (rxb1_wr),
		.txb_adr_i    (txb_adr),
		.txb_dat_o    (txb_dat)
	);

	minimac_tx tx (
		.phy_tx_clk_i  (phy_tx_clk_i),
		.tx_start_i    (phy_tx_start),
		.tx_count_i    (phy_tx_count),
		.txb_adr_o     (txb_adr),
		.txb_dat_i     (txb_dat),
		.tx_done_o     (phy_tx_done),
		.phy_tx_en_o   (phy_tx_en_o),
		.phy_tx_data_o (phy_tx_data_o)
	);

	minimac_rx rx (
		.phy_rx_clk_i  (phy_rx_clk_i),
		.rx_ready_i    (phy_rx_ready),
		.phy_dv_i      (phy_dv_i),
		.phy_rx_data_i (phy_rx_data_i),
		.rxb0_wr_o     (rxb0_wr),
		.rxb1_wr_o     (rxb1_wr),
		.rx_done_o     (phy_rx_done),
		.rx_count_0_o  (phy_rx_count_0),
		.rx_count_1_o  (phy_rx_count_1)
	);

	// No collision handling on the transmit side.
	assign phy_tx_er_o = 1'b0;

endmodule

//--- minimac_checker.sv
/*
 * Minimac assertion checker.
 * Bound onto the top level. Watches the Wishbone ack, the MII
 * transmit enable during reset and the rx interrupt level.
 */
`timescale 1ns/100ps

module minimac_checker import minimac_pkg::*; (
	input logic       sys_clk_i,
	input logic       reset_i,
	input logic       wb_ack_i,
	input logic       phy_tx_en_i,
	input logic       irq_rx_i,
	input logic [1:0] slot0_state_i,
	input logic [1:0] slot1_state_i
);

	// One-cycle ack only.
	ack_single: assert property (@(posedge sys_clk_i) disable iff (reset_i)
		wb_ack_i |=> !wb_ack_i)
		else $error("wb_ack_o high two cycles in a row");

	tx_quiet_in_reset: assert property (@(posedge sys_clk_i)
		reset_i |-> !phy_tx_en_i)
		else $error("phy_tx_en_o high during reset");

	irq_has_pending: assert property (@(posedge sys_clk_i) disable iff (reset_i)
		irq_rx_i |-> (slot0_state_i == PENDING || slot1_state_i == PENDING))
		else $error("irq_rx_o high with no slot pending");

endmodule

bind minimac minimac_checker sva_chk (
	.sys_clk_i     (sys_clk_i),
	.reset_i       (reset_i),
	.wb_ack_i      (wb_ack_o),
	.phy_tx_en_i   (phy_tx_en_o),
	.irq_rx_i      (irq_rx_o),
	.slot0_state_i (ctlif.slot_state[0]),
	.slot1_state_i (ctlif.slot_state[1])
);

//--- minimac_ctlif.sv
/*
 * Minimac control interface.
 * CSR registers for setup, rx slot state and tx count.
 * Raises the rx and tx interrupt levels and drives the PHY reset.
 */
`timescale 1ns/100ps
`include "minimac_macros.svh"

module minimac_ctlif import minimac_pkg::*; (
	input  logic                       sys_clk_i,
	input  logic                       reset_i,
	input  logic [13:0]                csr_a_i,
	input  logic                       csr_we_i,
	input  logic [31:0]                csr_di_i,
	output logic [31:0]                csr_do_o,
	output logic                       irq_rx_o,
	output logic                       irq_tx_o,
	output logic                       phy_rst_n_o,
	output sys2phy_t                   to_phy_o,
	input  phy2sys_t                   from_phy_i
);

	csr_word_u wr_word;
	csr_word_u rd_word;
	logic csr_sel;
	logic csr_wr;
	logic tx_write;

	logic phy_reset;
	logic rx_irq_en;
	logic tx_irq_en;
	slot_state_e slot_state [2];
	logic [`MINIMAC_BUF_AW-1:0] slot_count [2];
	logic [`MINIMAC_BUF_AW-1:0] rx_count [2];
	logic tx_start;
	logic tx_pend;
	logic [`MINIMAC_BUF_AW-1:0] tx_count;

	assign wr_word = csr_di_i;
	assign csr_sel = (csr_a_i[13:10] == `MINIMAC_CSR_SEL);
	assign csr_wr = csr_sel && csr_we_i;
	// A start while busy or with zero length is ignored.
	assign tx_write = csr_wr && (csr_a_i[2:0] == 3'd5) && !tx_start &&
		(wr_word.slot.count != '0);

	assign rx_count[0] = from_phy_i.rx_count_0;
	assign rx_count[1] = from_phy_i.rx_count_1;

	// ====================
	// Control state.
	// ====================
	always_ff @(posedge sys_clk_i) begin
		if (reset_i) begin
			phy_reset <= 1'b1;
			rx_irq_en <= 1'b0;
			tx_irq_en <= 1'b0;
			slot_state[0] <= EMPTY;
			slot_state[1] <= EMPTY;
			tx_start <= 1'b0;
			tx_pend <= 1'b0;
		end else begin
			if (csr_wr) begin
				case (csr_a_i[2:0])
					3'd0: begin
						phy_reset <= wr_word.setup.phy_reset;
						rx_irq_en <= wr_word.setup.rx_irq_en;
						tx_irq_en <= wr_word.setup.tx_irq_en;
					end
					3'd1: slot_state[0] <= wr_word.slot.state;
					3'd3: slot_state[1] <= wr_word.slot.state;
					default: ;
				endcase
			end
			if (tx_write) begin
				tx_start <= 1'b1;
				tx_pend <= 1'b0;
			end
			// Received frame wins over a software write in the same cycle.
			for (int i = 0; i < 2; i++) begin
				if (from_phy_i.rx_done[i] && slot_state[i] == LOADED)
					slot_state[i] <= PENDING;
			end
			if (from_phy_i.tx_done) begin
				tx_start <= 1'b0;
				tx_pend <= 1'b1;
			end
		end
	end

	always_ff @(posedge sys_clk_i) begin
		for (int i = 0; i < 2; i++) begin
			if (from_phy_i.rx_done[i] && slot_state[i] == LOADED)
				slot_count[i] <= rx_count[i];
		end
		if (tx_write)
			tx_count <= wr_word.slot.count;
	end

	// ====================
	// Read back.
	// ====================
	always_comb begin
		rd_word = '0;
		case (csr_a_i[2:0])
			3'd0: begin
				rd_word.setup.phy_reset = phy_reset;
				rd_word.setup.rx_irq_en = rx_irq_en;
				rd_word.setup.tx_irq_en = tx_irq_en;
			end
			3'd1: begin
				rd_word.slot.state = slot_state[0];
				rd_word.slot.count = slot_count[0];
			end
			3'd2: rd_word.slot.count = slot_count[0];
			3'd3: begin
				rd_word.slot.state = slot_state[1];
				rd_word.slot.count = slot_count[1];
			end
			3'd4: rd_word.slot.count = slot_count[1];
			3'd5: rd_word.slot.count = tx_count;
			default: ;
		endcase
	end

	always_ff @(posedge sys_clk_i) begin
		if (reset_i)
			csr_do_o <= '0;
		else
			csr_do_o <= csr_sel ? rd_word : '0;
	end

	always_comb begin
		to_phy_o.rx_ready[0] = (slot_state[0] == LOADED);
		to_phy_o.rx_ready[1] = (slot_state[1] == LOADED);
		to_phy_o.tx_start = tx_start;
		to_phy_o.tx_count = tx_count;
	end

	assign irq_rx_o = rx_irq_en &&
		(slot_state[0] == PENDING || slot_state[1] == PENDING);
	assign irq_tx_o = tx_irq_en && tx_pend;
	assign phy_rst_n_o = ~phy_reset;

endmodule

//--- minimac_macros.svh
/*
 * Minimac shared constants.
 * Buffer geometry, CSR block select and MII preamble nibbles.
 */
`ifndef MINIMAC_MACROS_SVH
`define MINIMAC_MACROS_SVH

// Byte address width of one frame buffer.
`define MINIMAC_BUF_AW 11

// Value of csr_a_i[13:10] that selects this block.
`define MINIMAC_CSR_SEL 4'h0

// Preamble nibbles before the SFD, then the SFD itself.
`define MINIMAC_PRE_NIBBLES 4'd15
`define MINIMAC_PRE_NIBBLE 4'h5
`define MINIMAC_SFD 4'hD

`endif

//--- minimac_memory.sv
/*
 * Minimac frame memory.
 * Two rx slots and one tx buffer, each split into four byte lanes.
 * Wishbone side reads all three, writes the tx buffer.
 */
`timescale 1ns/100ps
`include "minimac_macros.svh"

module minimac_memory import minimac_pkg::*; (
	input  logic                       sys_clk_i,
	input  logic                       reset_i,
	input  logic                       phy_tx_clk_i,
	input  logic                       phy_rx_clk_i,
	input  logic [31:0]                wb_adr_i,
	input  logic [31:0]                wb_dat_i,
	output logic [31:0]                wb_dat_o,
	input  logic [3:0]                 wb_sel_i,
	input  logic                       wb_stb_i,
	input  logic                       wb_cyc_i,
	input  logic                       wb_we_i,
	output logic                       wb_ack_o,
	input  buf_wr_t                    rxb0_wr_i,
	input  buf_wr_t                    rxb1_wr_i,
	input  logic [`MINIMAC_BUF_AW-1:0] txb_adr_i,
	output logic [7:0]                 txb_dat_o
);

	localparam int ROWS = 1 << (`MINIMAC_BUF_AW - 2);

	// Lane k holds byte address offset k of each word.
	logic [7:0] rxb_mem [2][4][ROWS];
	logic [7:0] txb_mem [4][ROWS];

	buf_wr_t rxb_wr [2];
	logic [`MINIMAC_BUF_AW-3:0] wb_row;
	logic wb_req;

	assign rxb_wr[0] = rxb0_wr_i;
	assign rxb_wr[1] = rxb1_wr_i;
	assign wb_row = wb_adr_i[`MINIMAC_BUF_AW-1:2];
	assign wb_req = wb_cyc_i && wb_stb_i && !wb_ack_o;

	always_ff @(posedge sys_clk_i) begin
		if (reset_i)
			wb_ack_o <= 1'b0;
		else
			wb_ack_o <= wb_req;
	end

	// Big-endian lanes. Offset 0 on bits 31..24.
	always_ff @(posedge sys_clk_i) begin
		for (int k = 0; k < 4; k++) begin
			case (wb_adr_i[12:11])
				2'd0: wb_dat_o[31-8*k -: 8] <= rxb_mem[0][k][wb_row];
				2'd1: wb_dat_o[31-8*k -: 8] <= rxb_mem[1][k][wb_row];
				default: wb_dat_o[31-8*k -: 8] <= txb_mem[k][wb_row];
			endcase
			if (wb_req && wb_we_i && wb_adr_i[12:11] == 2'd2 && wb_sel_i[3-k])
				txb_mem[k][wb_row] <= wb_dat_i[31-8*k -: 8];
		end
	end

	always_ff @(posedge phy_rx_clk_i) begin
		for (int s = 0; s < 2; s++) begin
			if (rxb_wr[s].we)
				rxb_mem[s][rxb_wr[s].adr[1:0]][rxb_wr[s].adr[`MINIMAC_BUF_AW-1:2]] <=
					rxb_wr[s].dat;
		end
	end

	always_ff @(posedge phy_tx_clk_i) begin
		txb_dat_o <= txb_mem[txb_adr_i[1:0]][txb_adr_i[`MINIMAC_BUF_AW-1:2]];
	end

endmodule

//--- minimac_pkg.sv
/*
 * Minimac shared types.
 * Clock crossing bundles, rx buffer write port and the CSR word views.
 */
`include "minimac_macros.svh"

package minimac_pkg;

	typedef enum logic [1:0] {
		EMPTY   = 2'd0,
		LOADED  = 2'd1,
		PENDING = 2'd2
	} slot_state_e;

	// Levels and count from the system side.
	typedef struct packed {
		logic [1:0] rx_ready;
		logic tx_start;
		logic [`MINIMAC_BUF_AW-1:0] tx_count;
	} sys2phy_t;

	// Done pulses and counts back into sys_clk.
	typedef struct packed {
		logic [1:0] rx_done;
		logic [`MINIMAC_BUF_AW-1:0] rx_count_0;
		logic [`MINIMAC_BUF_AW-1:0] rx_count_1;
		logic tx_done;
	} phy2sys_t;

	typedef struct packed {
		logic we;
		logic [`MINIMAC_BUF_AW-1:0] adr;
		logic [7:0] dat;
	} buf_wr_t;

	// Slot word. State sits just above the count.
	typedef struct packed {
		logic [31-`MINIMAC_BUF_AW-2:0] rsvd;
		slot_state_e state;
		logic [`MINIMAC_BUF_AW-1:0] count;
	} csr_slot_t;

	typedef struct packed {
		logic [28:0] rsvd;
		logic tx_irq_en;
		logic rx_irq_en;
		logic phy_reset;
	} csr_setup_t;

	typedef union packed {
		csr_slot_t slot;
		csr_setup_t setup;
	} csr_word_u;

endpackage

//--- minimac_rx.sv
/*
 * Minimac receiver.
 * Picks a ready slot, strips the preamble up to the SFD and
 * writes assembled bytes into that slot.
 */
`timescale 1ns/100ps
`include "minimac_macros.svh"

module minimac_rx import minimac_pkg::*; (
	input  logic                       phy_rx_clk_i,
	input  logic [1:0]                 rx_ready_i,
	input  logic                       phy_dv_i,
	input  logic [3:0]                 phy_rx_data_i,
	output buf_wr_t                    rxb0_wr_o,
	output buf_wr_t                    rxb1_wr_o,
	output logic [1:0]                 rx_done_o,
	output logic [`MINIMAC_BUF_AW-1:0] rx_count_0_o,
	output logic [`MINIMAC_BUF_AW-1:0] rx_count_1_o
);

	typedef enum logic [1:0] {RX_IDLE, RX_PRE, RX_DATA, RX_DROP} rx_state_e;

	rx_state_e state = RX_IDLE;
	logic dv_q = 1'b0;
	logic slot = 1'b0;
	logic hi = 1'b0;
	logic [3:0] lo_nib;
	logic [`MINIMAC_BUF_AW-1:0] cnt = '0;
	buf_wr_t wr_q = '0;
	logic [1:0] done_q = '0;

	always_ff @(posedge phy_rx_clk_i) begin
		dv_q <= phy_dv_i;
		wr_q.we <= 1'b0;
		done_q <= 2'b00;
		case (state)
			RX_IDLE: if (phy_dv_i && !dv_q) begin
				if (rx_ready_i[0]) begin
					slot <= 1'b0;
					state <= RX_PRE;
				end else if (rx_ready_i[1]) begin
					slot <= 1'b1;
					state <= RX_PRE;
				end else begin
					state <= RX_DROP;
				end
			end
			RX_PRE: if (!phy_dv_i) begin
				state <= RX_IDLE;
			end else if (phy_rx_data_i == `MINIMAC_SFD) begin
				hi <= 1'b0;
				cnt <= '0;
				state <= RX_DATA;
			end
			RX_DATA: if (!phy_dv_i) begin
				// End of frame. Count goes out with the done pulse.
				done_q[slot] <= 1'b1;
				if (slot)
					rx_count_1_o <= cnt;
				else
					rx_count_0_o <= cnt;
				state <= RX_IDLE;
			end else if (!hi) begin
				lo_nib <= phy_rx_data_i;
				hi <= 1'b1;
			end else begin
				wr_q.we <= 1'b1;
				wr_q.adr <= cnt;
				wr_q.dat <= {phy_rx_data_i, lo_nib};
				cnt <= cnt + 1'b1;
				hi <= 1'b0;
			end
			// No slot free. Wait out the frame.
			RX_DROP: if (!phy_dv_i) state <= RX_IDLE;
			default: state <= RX_IDLE;
		endcase
	end

	always_comb begin
		rxb0_wr_o = wr_q;
		rxb0_wr_o.we = wr_q.we && !slot;
		rxb1_wr_o = wr_q;
		rxb1_wr_o.we = wr_q.we && slot;
	end

	assign rx_done_o = done_q;

endmodule

//--- minimac_scoreboard.sv
/*
 * Minimac scoreboard.
 * Collects MII transmit nibbles and Wishbone read data from the DUT
 * pins and compares them with what the testbench expects.
 * Prints one line per test and a closing count line.
 */
`timescale 1ns/100ps

module minimac_scoreboard (
	input  logic        sys_clk_i,
	input  logic        phy_tx_clk_i,
	input  logic        wb_ack_i,
	input  logic        wb_we_i,
	input  logic [31:0] wb_dat_i,
	input  logic        phy_tx_en_i,
	input  logic [3:0]  phy_tx_data_i,
	output int          err_cnt_o
);

	int errors = 0;
	int mark = 0;
	int tests = 0;
	int failed = 0;
	logic [31:0] word_q [$];
	logic [31:0] mask_q [$];
	logic [3:0] tx_exp_q [$];
	logic [3:0] tx_got_q [$];
	bit tx_armed = 1'b0;
	logic en_q = 1'b0;

	assign err_cnt_o = errors;

	// ====================
	// Tasks for the testbench.
	// ====================
	task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			errors++;
			$display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic fail_msg(input string what);
		errors++;
		$display("Failure at %0t ns: %s", $time, what);
	endtask

	task automatic expect_word(input logic [31:0] exp, input logic [31:0] mask);
		word_q.push_back(exp);
		mask_q.push_back(mask);
	endtask

	// Preamble, SFD, then each byte low nibble first.
	task automatic expect_tx(input logic [7:0] data [64], input int len);
		tx_exp_q.delete();
		repeat (15) tx_exp_q.push_back(4'h5);
		tx_exp_q.push_back(4'hD);
		for (int i = 0; i < len; i++) begin
			tx_exp_q.push_back(data[i][3:0]);
			tx_exp_q.push_back(data[i][7:4]);
		end
		tx_armed = 1'b1;
	endtask

	task automatic end_test(input string name);
		// Last Wishbone read lands at the next rising edge.
		@(negedge sys_clk_i);
		if (tx_armed)
			fail_msg("no transmit frame was seen on MII");
		if (word_q.size() > 0)
			fail_msg("an expected Wishbone read never completed");
		tests++;
		if (errors != mark)
			failed++;
		$display("test %0d %s: %s", tests, name, (errors == mark) ? "ok" : "errors");
		mark = errors;
	endtask

	task automatic report();
		$display("%0d tests, %0d failed, %0d errors", tests, failed, errors);
	endtask

	task automatic check_frame();
		if (!tx_armed) begin
			fail_msg("a frame was sent with none expected");
		end else begin
			compare("phy_tx_en_o nibble count", tx_exp_q.size(), tx_got_q.size());
			for (int i = 0; i < tx_exp_q.size() && i < tx_got_q.size(); i++)
				compare("phy_tx_data_o", tx_exp_q[i], tx_got_q[i]);
		end
		tx_armed = 1'b0;
		tx_got_q.delete();
	endtask

	// ====================
	// Pin monitors.
	// ====================
	always @(posedge sys_clk_i) begin
		logic [31:0] exp_w;
		logic [31:0] mask_w;
		if (wb_ack_i && !wb_we_i) begin
			if (word_q.size() == 0) begin
				fail_msg("Wishbone read returned data with nothing expected");
			end else begin
				exp_w = word_q.pop_front();
				mask_w = mask_q.pop_front();
				compare("wb_dat_o", exp_w & mask_w, wb_dat_i & mask_w);
			end
		end
	end

	// Frame ends on the falling enable.
	always @(posedge phy_tx_clk_i) begin
		if (phy_tx_en_i)
			tx_got_q.push_back(phy_tx_data_i);
		else if (en_q)
			check_frame();
		en_q = phy_tx_en_i;
	end

endmodule

//--- minimac_sync.sv
/*
 * Minimac clock crossing.
 * Two-flop sync of ready and start levels into the PHY clocks.
 * Toggle sync of the done pulses back into sys_clk.
 */
`timescale 1ns/100ps
`include "minimac_macros.svh"

module minimac_sync import minimac_pkg::*; (
	input  logic                       sys_clk_i,
	input  logic                       phy_rx_clk_i,
	input  logic                       phy_tx_clk_i,
	input  sys2phy_t                   sys_to_phy_i,
	output logic [1:0]                 rx_ready_o,
	output logic                       tx_start_o,
	output logic [`MINIMAC_BUF_AW-1:0] tx_count_o,
	input  logic [1:0]                 rx_done_i,
	input  logic [`MINIMAC_BUF_AW-1:0] rx_count_0_i,
	input  logic [`MINIMAC_BUF_AW-1:0] rx_count_1_i,
	input  logic                       tx_done_i,
	output phy2sys_t                   phy_to_sys_o
);

	logic [1:0] rx_ready_s1 = '0;
	logic [1:0] rx_ready_s2 = '0;
	logic tx_start_s1 = 1'b0;
	logic tx_start_s2 = 1'b0;

	logic [1:0] rx_tgl = '0;
	logic [1:0] rx_tgl_s1 = '0;
	logic [1:0] rx_tgl_s2 = '0;
	logic [1:0] rx_tgl_s3 = '0;
	logic tx_tgl = 1'b0;
	logic tx_tgl_s1 = 1'b0;
	logic tx_tgl_s2 = 1'b0;
	logic tx_tgl_s3 = 1'b0;

	// Levels into the PHY domains.
	always_ff @(posedge phy_rx_clk_i) begin
		rx_ready_s1 <= sys_to_phy_i.rx_ready;
		rx_ready_s2 <= rx_ready_s1;
		rx_tgl <= rx_tgl ^ rx_done_i;
	end

	always_ff @(posedge phy_tx_clk_i) begin
		tx_start_s1 <= sys_to_phy_i.tx_start;
		tx_start_s2 <= tx_start_s1;
		tx_tgl <= tx_tgl ^ tx_done_i;
	end

	// Toggles into sys_clk. Third stage is for edge detect.
	always_ff @(posedge sys_clk_i) begin
		rx_tgl_s1 <= rx_tgl;
		rx_tgl_s2 <= rx_tgl_s1;
		rx_tgl_s3 <= rx_tgl_s2;
		tx_tgl_s1 <= tx_tgl;
		tx_tgl_s2 <= tx_tgl_s1;
		tx_tgl_s3 <= tx_tgl_s2;
	end

	assign rx_ready_o = rx_ready_s2;
	assign tx_start_o = tx_start_s2;
	// Count is stable while tx_start is high.
	assign tx_count_o = sys_to_phy_i.tx_count;

	always_comb begin
		phy_to_sys_o.rx_done = rx_tgl_s3 ^ rx_tgl_s2;
		phy_to_sys_o.rx_count_0 = rx_count_0_i;
		phy_to_sys_o.rx_count_1 = rx_count_1_i;
		phy_to_sys_o.tx_done = tx_tgl_s3 ^ tx_tgl_s2;
	end

endmodule

//--- minimac_tx.sv
/*
 * Minimac transmitter.
 * Sends preamble and SFD, then the tx buffer low nibble first.
 */
`timescale 1ns/100ps
`include "minimac_macros.svh"

module minimac_tx (
	input  logic                       phy_tx_clk_i,
	input  logic                       tx_start_i,
	input  logic [`MINIMAC_BUF_AW-1:0] tx_count_i,
	output logic [`MINIMAC_BUF_AW-1:0] txb_adr_o,
	input  logic [7:0]                 txb_dat_i,
	output logic                       tx_done_o,
	output logic                       phy_tx_en_o,
	output logic [3:0]                 phy_tx_data_o
);

	typedef enum logic [2:0] {
		TX_IDLE, TX_PRE, TX_LO, TX_HI, TX_END, TX_WAIT
	} tx_state_e;

	tx_state_e state = TX_IDLE;
	logic [3:0] pre_cnt = '0;
	logic [`MINIMAC_BUF_AW-1:0] adr = '0;
	logic en_q = 1'b0;
	logic [3:0] data_q = '0;
	logic done_q = 1'b0;

	// Read data lags the address by one cycle, so the HI nibble
	// still sees the byte fetched for LO.
	always_ff @(posedge phy_tx_clk_i) begin
		done_q <= 1'b0;
		case (state)
			TX_IDLE: if (tx_start_i) begin
				adr <= '0;
				pre_cnt <= '0;
				state <= TX_PRE;
			end
			TX_PRE: begin
				en_q <= 1'b1;
				pre_cnt <= pre_cnt + 1'b1;
				if (pre_cnt == `MINIMAC_PRE_NIBBLES) begin
					data_q <= `MINIMAC_SFD;
					state <= TX_LO;
				end else begin
					data_q <= `MINIMAC_PRE_NIBBLE;
				end
			end
			TX_LO: begin
				data_q <= txb_dat_i[3:0];
				adr <= adr + 1'b1;
				state <= TX_HI;
			end
			TX_HI: begin
				data_q <= txb_dat_i[7:4];
				state <= (adr == tx_count_i) ? TX_END : TX_LO;
			end
			TX_END: begin
				en_q <= 1'b0;
				data_q <= '0;
				done_q <= 1'b1;
				state <= TX_WAIT;
			end
			// Hold off until software start is seen low.
			TX_WAIT: if (!tx_start_i) state <= TX_IDLE;
			default: state <= TX_IDLE;
		endcase
	end

	assign txb_adr_o = adr;
	assign tx_done_o = done_q;
	assign phy_tx_en_o = en_q;
	assign phy_tx_data_o = data_q;

endmodule

//--- tb_minimac.sv
/*
 * Minimac testbench.
 * Clocks, reset, a table of transmit, receive and drop tests,
 * CSR and Wishbone bus tasks and a run watchdog.
 */
`timescale 1ns/100ps
`include "minimac_macros.svh"

module tb_minimac;

	localparam int N_TESTS = 5;
	localparam int K_RESET = 0;
	localparam int K_TX = 1;
	localparam int K_RX = 2;
	localparam int K_DROP = 3;

	// Kind, payload length and the slot the frame must land in.
	int kind_tab [N_TESTS] = '{K_RESET, K_TX, K_RX, K_RX, K_DROP};
	int len_tab [N_TESTS] = '{0, 13, 9, 7, 5};
	int slot_tab [N_TESTS] = '{0, 0, 0, 1, 0};
	string name_tab [N_TESTS] = '{"reset", "transmit", "receive", "alternate", "drop"};

	logic sys_clk = 1'b0;
	logic phy_tx_clk = 1'b0;
	logic phy_rx_clk = 1'b0;
	logic reset;
	logic [13:0] csr_a;
	logic csr_we;
	logic [31:0] csr_di;
	logic [31:0] csr_do;
	logic irq_rx;
	logic irq_tx;
	logic [31:0] wb_adr;
	logic [31:0] wb_dat_w;
	logic [31:0] wb_dat_r;
	logic [3:0] wb_sel;
	logic wb_stb;
	logic wb_cyc;
	logic wb_we;
	logic wb_ack;
	logic [3:0] phy_tx_data;
	logic phy_tx_en;
	logic phy_tx_er;
	logic [3:0] phy_rx_data;
	logic phy_dv;
	logic phy_rst_n;

	integer seed;
	int wd_cycles = 0;
	int err_cnt;
	int len;
	logic [7:0] payload [64];
	logic [7:0] slot_data [2][64];
	int last_cnt [2];

	always #4 sys_clk = ~sys_clk;
	always #20 phy_tx_clk = ~phy_tx_clk;
	always #20 phy_rx_clk = ~phy_rx_clk;

	minimac UUT (
		.sys_clk_i(sys_clk), .reset_i(reset),
		.csr_a_i(csr_a), .csr_we_i(csr_we), .csr_di_i(csr_di), .csr_do_o(csr_do),
		.irq_rx_o(irq_rx), .irq_tx_o(irq_tx),
		.wb_adr_i(wb_adr), .wb_dat_i(wb_dat_w), .wb_dat_o(wb_dat_r), .wb_sel_i(wb_sel),
		.wb_stb_i(wb_stb), .wb_cyc_i(wb_cyc), .wb_we_i(wb_we), .wb_ack_o(wb_ack),
		.phy_tx_clk_i(phy_tx_clk), .phy_tx_data_o(phy_tx_data), .phy_tx_en_o(phy_tx_en),
		.phy_tx_er_o(phy_tx_er), .phy_rx_clk_i(phy_rx_clk), .phy_rx_data_i(phy_rx_data),
		.phy_dv_i(phy_dv), .phy_rst_n_o(phy_rst_n)
	);

	minimac_scoreboard sb (
		.sys_clk_i(sys_clk), .phy_tx_clk_i(phy_tx_clk), .wb_ack_i(wb_ack), .wb_we_i(wb_we),
		.wb_dat_i(wb_dat_r), .phy_tx_en_i(phy_tx_en), .phy_tx_data_i(phy_tx_data),
		.err_cnt_o(err_cnt)
	);

	// ====================
	// Bus tasks.
	// ====================
	task automatic csr_write(input int idx, input logic [31:0] d);
		@(negedge sys_clk);
		csr_a = idx[13:0];
		csr_di = d;
		csr_we = 1'b1;
		@(negedge sys_clk);
		csr_we = 1'b0;
	endtask

	task automatic csr_read(input int idx, output logic [31:0] d);
		@(negedge sys_clk);
		csr_a = idx[13:0];
		csr_we = 1'b0;
		@(negedge sys_clk);
		d = csr_do;
	endtask

	// Leaves wb_we as it was so the scoreboard sees it with the ack.
	task automatic wb_access(input logic [31:0] adr, input logic we,
			input logic [31:0] d, input logic [3:0] sel);
		int n;
		n = 0;
		@(negedge sys_clk);
		wb_adr = adr;
		wb_we = we;
		wb_dat_w = d;
		wb_sel = sel;
		wb_stb = 1'b1;
		wb_cyc = 1'b1;
		do begin
			@(negedge sys_clk);
			n++;
		end while (!wb_ack && n < 16);
		if (!wb_ack)
			sb.fail_msg("Wishbone access got no ack");
		wb_stb = 1'b0;
		wb_cyc = 1'b0;
	endtask

	task automatic read_slot(input int s);
		logic [31:0] exp;
		logic [31:0] mask;
		for (int w = 0; w < (last_cnt[s] + 3) / 4; w++) begin
			exp = '0;
			mask = '0;
			for (int k = 0; k < 4; k++) begin
				if (4 * w + k < last_cnt[s]) begin
					exp[31 - 8 * k -: 8] = slot_data[s][4 * w + k];
					mask[31 - 8 * k -: 8] = 8'hFF;
				end
			end
			sb.expect_word(exp, mask);
			wb_access((32'(s) << 11) | 32'(4 * w), 1'b0, '0, 4'hF);
		end
	endtask

	// ====================
	// MII and waits.
	// ====================
	task automatic send_frame();
		logic [3:0] nib [$];
		repeat (15) nib.push_back(4'h5);
		nib.push_back(4'hD);
		for (int i = 0; i < len; i++) begin
			nib.push_back(payload[i][3:0]);
			nib.push_back(payload[i][7:4]);
		end
		foreach (nib[i]) begin
			@(negedge phy_rx_clk);
			phy_dv = 1'b1;
			phy_rx_data = nib[i];
		end
		@(negedge phy_rx_clk);
		phy_dv = 1'b0;
		phy_rx_data = 4'h0;
	endtask

	task automatic wait_irq_tx(input int limit);
		int n;
		n = 0;
		while (!irq_tx && n < limit) begin
			@(negedge sys_clk);
			n++;
		end
		if (!irq_tx)
			sb.fail_msg("irq_tx_o never rose after the transmit");
	endtask

	// Polls the slot state word until the frame is marked received.
	task automatic wait_pending(input int s, input int limit, output logic [31:0] d);
		int n;
		n = 0;
		d = '0;
		while (d[12:11] != 2'd2 && n < limit) begin
			csr_read(1 + 2 * s, d);
			n++;
		end
	endtask

	// ====================
	// Test sequence.
	// ====================
	initial begin
		logic [31:0] rd;
		logic [31:0] word;
		logic [3:0] sel;
		logic [31:0] rnd;
		int s;
		seed = 60;
		reset = 1'b1;
		csr_a = '0;
		csr_we = 1'b0;
		csr_di = '0;
		wb_adr = '0;
		wb_dat_w = '0;
		wb_sel = '0;
		wb_stb = 1'b0;
		wb_cyc = 1'b0;
		wb_we = 1'b0;
		phy_rx_data = '0;
		phy_dv = 1'b0;
		last_cnt[0] = 0;
		last_cnt[1] = 0;
		for (int t = 0; t < N_TESTS; t++)
			wd_cycles += 40 * len_tab[t] + 200;
		repeat (5) @(posedge sys_clk);
		@(negedge sys_clk);
		reset = 1'b0;

		for (int t = 0; t < N_TESTS; t++) begin
			len = len_tab[t];
			s = slot_tab[t];
			for (int i = 0; i < len; i++) begin
				rnd = $random(seed);
				payload[i] = rnd[7:0];
			end
			case (kind_tab[t])
				K_RESET: begin
					sb.compare("irq_rx_o", 0, irq_rx);
					sb.compare("irq_tx_o", 0, irq_tx);
					sb.compare("wb_ack_o", 0, wb_ack);
					sb.compare("phy_tx_en_o", 0, phy_tx_en);
					sb.compare("phy_tx_er_o", 0, phy_tx_er);
					sb.compare("phy_rst_n_o", 0, phy_rst_n);
					// Release the PHY and enable both interrupts.
					csr_write(0, 32'h6);
					sb.compare("phy_rst_n_o", 1, phy_rst_n);
				end
				K_TX: begin
					for (int w = 0; w < (len + 3) / 4; w++) begin
						word = '0;
						sel = '0;
						for (int k = 0; k < 4; k++) begin
							if (4 * w + k < len) begin
								word[31 - 8 * k -: 8] = payload[4 * w + k];
								sel[3 - k] = 1'b1;
							end
						end
						wb_access(32'h1000 | 32'(4 * w), 1'b1, word, sel);
					end
					sb.expect_tx(payload, len);
					csr_write(5, len);
					wait_irq_tx(5 * (40 * len + 200));
				end
				K_RX: begin
					csr_write(1 + 2 * s, 32'h800);
					repeat (4) @(negedge phy_rx_clk);
					send_frame();
					wait_pending(s, 40 * len + 200, rd);
					sb.compare("slot state word", (32'd2 << 11) | 32'(len), rd);
					sb.compare("irq_rx_o", 1, irq_rx);
					for (int i = 0; i < len; i++)
						slot_data[s][i] = payload[i];
					last_cnt[s] = len;
					read_slot(0);
					if (s == 1)
						read_slot(1);
				end
				default: begin
					csr_write(1, 32'h0);
					csr_write(3, 32'h0);
					sb.compare("irq_rx_o", 0, irq_rx);
					send_frame();
					// No done comes back, so allow for the crossing.
					repeat (40) @(negedge sys_clk);
					csr_read(1, rd);
					sb.compare("slot 0 state word", 32'(last_cnt[0]), rd);
					csr_read(3, rd);
					sb.compare("slot 1 state word", 32'(last_cnt[1]), rd);
					sb.compare("irq_rx_o", 0, irq_rx);
					read_slot(0);
					read_slot(1);
				end
			endcase
			sb.end_test(name_tab[t]);
		end

		sb.report();
		if (err_cnt == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

	// Limit follows the table: 40 PHY cycles per byte plus 200 per test.
	initial begin
		wait (wd_cycles > 0);
		#(wd_cycles * 40);
		$display("Watchdog expired before the tests finished");
		$display("TEST FAILED");
		$finish;
	end

endmodule
